/* Bender.yml */
package:
  name: sram_subsystem

export_include_dirs:
  - src

sources:
  - src/sram_pkg.sv
  - src/lfsr_random.sv
  - src/latency_delay.sv
  - src/delay_config.sv
  - src/sram_array.sv
  - src/axi_sram.sv
  - src/sram_top.sv
  - target: test
    files:
      - tb/tb_sram_top.sv

/* filelist.f */
+incdir+src
src/sram_pkg.sv
src/lfsr_random.sv
src/latency_delay.sv
src/delay_config.sv
src/sram_array.sv
src/axi_sram.sv
src/sram_top.sv
tb/tb_sram_top.sv

/* src/axi_sram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sram_defs.svh"

module axi_sram import sram_pkg::*; (
	input logic clk,
	input logic reset,

	input ar_req_t ar,
	input logic ar_valid,
	output logic ar_ready,

	output r_rsp_t r,
	output logic r_valid,
	input logic r_ready,

	input aw_req_t aw,
	input logic aw_valid,
	output logic aw_ready,

	input w_req_t w,
	input logic w_valid,
	output logic w_ready,

	output resp_t b_resp,
	output logic b_valid,
	input logic b_ready,

	input mask_t delay_mask,
	input rand_t rand_val,

	output logic rd_en,
	output index_t rd_index,
	input word_t rd_data,
	output logic wr_en,
	output index_t wr_index,
	output word_t wr_data,
	output strb_t wr_strb
);

	localparam int OFFSET_W = $clog2(`SRAM_DATA_W / 8);

	function automatic logic in_range(input addr_t addr);
		return addr[`SRAM_ADDR_W-1:OFFSET_W] < `SRAM_DEPTH;
	endfunction

	function automatic index_t to_index(input addr_t addr);
		return addr[OFFSET_W +: $bits(index_t)];
	endfunction

	logic ar_fire;
	logic r_fire;
	logic aw_fire;
	logic w_fire;
	logic b_fire;

	logic rd_pending;
	resp_t rd_resp;

	logic aw_held;
	logic w_held;
	logic wr_pending;
	logic wr_committed;
	logic aw_ok;
	aw_req_t aw_q;
	w_req_t w_q;

	assign ar_fire = ar_valid && ar_ready;
	assign r_fire = r_valid && r_ready;
	assign aw_fire = aw_valid && aw_ready;
	assign w_fire = w_valid && w_ready;
	assign b_fire = b_valid && b_ready;

	// read path: array is read on the address handshake itself.
	assign ar_ready = !rd_pending;
	assign rd_en = ar_fire;
	assign rd_index = to_index(ar.addr);

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_pending <= 1'b0;
		end else if (ar_fire) begin
			rd_pending <= 1'b1;
		end else if (r_fire) begin
			rd_pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire) begin
			rd_resp <= in_range(ar.addr) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	assign r.data = (rd_resp == RESP_OKAY) ? rd_data : '0;
	assign r.resp = rd_resp;

	latency_delay read_delay (
		.clk(clk),
		.reset(reset),
		.pending(rd_pending),
		.mask(delay_mask),
		.rand_val(rand_val),
		.ready_out(r_valid)
	);

	// write path: address and data are captured independently.
	assign aw_ready = !aw_held;
	assign w_ready = !w_held;
	assign wr_pending = aw_held && w_held;

	always_ff @(posedge clk) begin
		if (reset) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			wr_committed <= 1'b0;
		end else begin
			if (b_fire) begin
				aw_held <= 1'b0;
				w_held <= 1'b0;
			end else begin
				if (aw_fire) begin
					aw_held <= 1'b1;
				end
				if (w_fire) begin
					w_held <= 1'b1;
				end
			end

			if (b_fire) begin
				wr_committed <= 1'b0;
			end else if (b_valid) begin
				wr_committed <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (aw_fire) begin
			aw_q <= aw;
		end
		if (w_fire) begin
			w_q <= w;
		end
	end

	latency_delay write_delay (
		.clk(clk),
		.reset(reset),
		.pending(wr_pending),
		.mask(delay_mask),
		.rand_val(rand_val),
		.ready_out(b_valid)
	);

	assign aw_ok = in_range(aw_q.addr);
	assign b_resp = aw_ok ? RESP_OKAY : RESP_SLVERR;

	// commit in the first response cycle, out-of-range writes dropped.
	assign wr_en = b_valid && !wr_committed && aw_ok;
	assign wr_index = to_index(aw_q.addr);
	assign wr_data = w_q.data;
	assign wr_strb = w_q.strb;

	r_hold: assert property (@(posedge clk) disable iff (reset)
		r_valid && !r_ready |=> r_valid && $stable(r));

	wr_single: assert property (@(posedge clk) disable iff (reset)
		wr_en |=> !wr_en);

endmodule

`default_nettype wire

/* src/delay_config.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sram_defs.svh"

module delay_config import sram_pkg::*; (
	input logic clk,
	input logic reset,
	input logic cfg_wen,
	input mask_t cfg_mask,
	output mask_t delay_mask
);

	// up to three extra cycles out of reset.
	localparam mask_t RESET_MASK = 3;

	always_ff @(posedge clk) begin
		if (reset) begin
			delay_mask <= RESET_MASK;
		end else if (cfg_wen) begin
			delay_mask <= cfg_mask;
		end
	end

endmodule

`default_nettype wire

/* src/latency_delay.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sram_defs.svh"

module latency_delay import sram_pkg::*; (
	input logic clk,
	input logic reset,
	input logic pending,
	input mask_t mask,
	input rand_t rand_val,
	output logic ready_out
);

	delay_state_t state;
	mask_t count;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			count <= '0;
		end else begin
			case (state)
				idle: begin
					// extra delay is fixed at the start of the wait.
					if (pending) begin
						count <= rand_val[$bits(mask_t)-1:0] & mask;
						state <= counting;
					end
				end
				counting: begin
					if (!pending) begin
						state <= idle;
					end else if (count == '0) begin
						state <= done;
					end else begin
						count <= count - 1'b1;
					end
				end
				done: begin
					if (!pending) begin
						state <= idle;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// drops together with pending, so a taken response is never repeated.
	assign ready_out = (state == done) && pending;

	// at least two cycles of pending before the output may rise.
	min_latency: assert property (@(posedge clk) disable iff (reset)
		ready_out |-> pending && $past(pending) && $past(pending, 2));

endmodule

`default_nettype wire

/* src/lfsr_random.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sram_defs.svh"

module lfsr_random import sram_pkg::*; (
	input logic clk,
	input logic reset,
	output rand_t rand_val
);

	// x^8 + x^6 + x^5 + x^4 + 1, right-shifting form.
	localparam rand_t TAPS = 8'hb8;
	localparam rand_t SEED = 8'ha5;

	rand_t state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= SEED;
		end else begin
			state <= {1'b0, state[7:1]} ^ (state[0] ? TAPS : '0);
		end
	end

	assign rand_val = state;

endmodule

`default_nettype wire

/* src/sram_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sram_defs.svh"

module sram_array import sram_pkg::*; (
	input logic clk,

	input logic rd_en,
	input index_t rd_index,
	output word_t rd_data,

	input logic wr_en,
	input index_t wr_index,
	input word_t wr_data,
	input strb_t wr_strb
);

	word_t mem [`SRAM_DEPTH];

	// read data holds until the next read enable.
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_index];
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int i = 0; i < $bits(strb_t); i++) begin
				if (wr_strb[i]) begin
					mem[wr_index][i*8 +: 8] <= wr_data[i*8 +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/sram_defs.svh */
`ifndef SRAM_DEFS_SVH
`define SRAM_DEFS_SVH

// width of one stored word.
`define SRAM_DATA_W 32

// byte address width on the bus.
`define SRAM_ADDR_W 32

// words in the array, must be a power of two.
`define SRAM_DEPTH 256

// bounds the random extra response delay.
`define SRAM_MASK_W 4

`endif

/* src/sram_pkg.sv */
`default_nettype none

`include "sram_defs.svh"

package sram_pkg;

	typedef logic [`SRAM_DATA_W-1:0] word_t;
	typedef logic [`SRAM_ADDR_W-1:0] addr_t;
	typedef logic [`SRAM_DATA_W/8-1:0] strb_t;
	typedef logic [$clog2(`SRAM_DEPTH)-1:0] index_t;
	typedef logic [1:0] resp_t;
	typedef logic [`SRAM_MASK_W-1:0] mask_t;
	typedef logic [7:0] rand_t;

	localparam resp_t RESP_OKAY = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	typedef struct packed {
		addr_t addr;
	} ar_req_t;

	typedef struct packed {
		addr_t addr;
	} aw_req_t;

	typedef struct packed {
		word_t data;
		strb_t strb;
	} w_req_t;

	typedef struct packed {
		word_t data;
		resp_t resp;
	} r_rsp_t;

	typedef enum logic [1:0] {
		idle,
		counting,
		done
	} delay_state_t;

endpackage

`default_nettype wire

/* src/sram_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sram_defs.svh"

module sram_top import sram_pkg::*; (
	input logic clk,
	input logic reset,

	input ar_req_t ar,
	input logic ar_valid,
	output logic ar_ready,

	output r_rsp_t r,
	output logic r_valid,
	input logic r_ready,

	input aw_req_t aw,
	input logic aw_valid,
	output logic aw_ready,

	input w_req_t w,
	input logic w_valid,
	output logic w_ready,

	output resp_t b_resp,
	output logic b_valid,
	input logic b_ready,

	input logic cfg_wen,
	input mask_t cfg_mask
);

	mask_t delay_mask;
	rand_t rand_val;

	logic rd_en;
	index_t rd_index;
	word_t rd_data;
	logic wr_en;
	index_t wr_index;
	word_t wr_data;
	strb_t wr_strb;

	delay_config u_config (
		.clk(clk),
		.reset(reset),
		.cfg_wen(cfg_wen),
		.cfg_mask(cfg_mask),
		.delay_mask(delay_mask)
	);

	lfsr_random u_lfsr (
		.clk(clk),
		.reset(reset),
		.rand_val(rand_val)
	);

	axi_sram u_axi (
		.clk(clk),
		.reset(reset),
		.ar(ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r(r),
		.r_valid(r_valid),
		.r_ready(r_ready),
		.aw(aw),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.w(w),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.b_resp(b_resp),
		.b_valid(b_valid),
		.b_ready(b_ready),
		.delay_mask(delay_mask),
		.rand_val(rand_val),
		.rd_en(rd_en),
		.rd_index(rd_index),
		.rd_data(rd_data),
		.wr_en(wr_en),
		.wr_index(wr_index),
		.wr_data(wr_data),
		.wr_strb(wr_strb)
	);

	sram_array u_array (
		.clk(clk),
		.rd_en(rd_en),
		.rd_index(rd_index),
		.rd_data(rd_data),
		.wr_en(wr_en),
		.wr_index(wr_index),
		.wr_data(wr_data),
		.wr_strb(wr_strb)
	);

endmodule

`default_nettype wire

/* tb/tb_sram_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sram_defs.svh"

module tb_sram_top import sram_pkg::*; ();

	localparam int TIMEOUT = 200;
	localparam int BYTES = `SRAM_DATA_W / 8;

	typedef enum {chan_ar, chan_aw, chan_w, chan_r, chan_b} chan_t;

	logic clk;
	logic reset;
	ar_req_t ar;
	logic ar_valid;
	logic ar_ready;
	r_rsp_t r;
	logic r_valid;
	logic r_ready;
	aw_req_t aw;
	logic aw_valid;
	logic aw_ready;
	w_req_t w;
	logic w_valid;
	logic w_ready;
	resp_t b_resp;
	logic b_valid;
	logic b_ready;
	logic cfg_wen;
	mask_t cfg_mask;

	logic [31:0] lcg_state = 32'd96;
	int cycle_count = 0;
	int mismatch_count = 0;
	int failure_count = 0;
	int bp_max = 0;
	mask_t cur_mask = 3;
	logic [7:0] model_mem [int];
	int written [$];

	sram_top dut (
		.clk(clk),
		.reset(reset),
		.ar(ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r(r),
		.r_valid(r_valid),
		.r_ready(r_ready),
		.aw(aw),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.w(w),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.b_resp(b_resp),
		.b_valid(b_valid),
		.b_ready(b_ready),
		.cfg_wen(cfg_wen),
		.cfg_mask(cfg_mask)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// number of the most recent rising edge.
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	function logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	function automatic int rand_below(input int n);
		return int'(lcg_next()) % n;
	endfunction

	function automatic word_t rand_word();
		logic [15:0] hi;
		logic [15:0] lo;
		hi = lcg_next();
		lo = lcg_next();
		return {hi, lo};
	endfunction

	function automatic logic addr_in_range(input addr_t a);
		return a < `SRAM_DEPTH * BYTES;
	endfunction

	function automatic int word_slot(input addr_t a);
		return a / BYTES;
	endfunction

	function automatic word_t model_word(input int slot);
		word_t val;
		for (int i = 0; i < BYTES; i++) begin
			val[i*8 +: 8] = model_mem[slot*BYTES + i];
		end
		return val;
	endfunction

	function automatic void model_write(input int slot, input word_t d, input strb_t s);
		for (int i = 0; i < BYTES; i++) begin
			if (s[i]) begin
				model_mem[slot*BYTES + i] = d[i*8 +: 8];
			end
		end
	endfunction

	// mostly known words, now and then an aliased address past the array.
	function automatic addr_t pick_addr();
		int slot;
		slot = written[rand_below(written.size())];
		if (rand_below(8) == 0) begin
			return addr_t'((slot + (1 + rand_below(64)) * `SRAM_DEPTH) * BYTES);
		end
		return addr_t'(slot * BYTES);
	endfunction

	function automatic logic chan_level(input chan_t c);
		case (c)
			chan_ar: return ar_ready;
			chan_aw: return aw_ready;
			chan_w: return w_ready;
			chan_r: return r_valid;
			default: return b_valid;
		endcase
	endfunction

	function automatic string chan_name(input chan_t c);
		case (c)
			chan_ar: return "read address";
			chan_aw: return "write address";
			chan_w: return "write data";
			chan_r: return "read response";
			default: return "write response";
		endcase
	endfunction

	task automatic check_rdata(input string sig, input word_t got, input word_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s got %h expected %h", $time, sig, got, exp);
		end
	endtask

	task automatic check_rresp(input string sig, input resp_t got, input resp_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s got %0d expected %0d", $time, sig, got, exp);
		end
	endtask

	task automatic check_bresp(input string sig, input resp_t got, input resp_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s got %0d expected %0d", $time, sig, got, exp);
		end
	endtask

	task automatic check_latency(input string sig, input int got);
		if (got < 2 || got > 2 + int'(cur_mask)) begin
			mismatch_count++;
			$display("mismatch at %0t: %s latency got %0d expected %0d to %0d",
				$time, sig, got, 2, 2 + int'(cur_mask));
		end
	endtask

	task automatic check_flag(input logic cond, input string what);
		if (cond !== 1'b1) begin
			failure_count++;
			$display("error at %0t: %s", $time, what);
		end
	endtask

	task automatic finish_run();
		$display("checks done: %0d mismatches, %0d other errors",
			mismatch_count, failure_count);
		if (mismatch_count + failure_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	endtask

	task automatic report_hang(input string chan);
		failure_count++;
		$display("timeout at %0t: the %s channel hung for %0d cycles", $time, chan, TIMEOUT);
		finish_run();
	endtask

	// returns at the falling edge where the level is seen high.
	task automatic wait_high(input chan_t c);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!chan_level(c) && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!chan_level(c)) begin
			report_hang(chan_name(c));
		end
	endtask

	task automatic set_valid(input chan_t c, input logic v);
		case (c)
			chan_ar: ar_valid = v;
			chan_aw: aw_valid = v;
			default: w_valid = v;
		endcase
	endtask

	task automatic handshake(input chan_t c);
		set_valid(c, 1'b1);
		wait_high(c);
		@(posedge clk);
		#1;
		set_valid(c, 1'b0);
	endtask

	task automatic set_mask(input mask_t m);
		cfg_mask = m;
		cfg_wen = 1'b1;
		@(posedge clk);
		#1;
		cfg_wen = 1'b0;
		cur_mask = m;
	endtask

	task automatic accept_r(output r_rsp_t got);
		int stall;
		stall = (bp_max > 0) ? rand_below(bp_max + 1) : 0;
		got = r;
		repeat (stall) begin
			@(posedge clk);
			#1;
			@(negedge clk);
			check_flag(r_valid, "r_valid dropped before r_ready");
			check_rdata("r.data", r.data, got.data);
			check_rresp("r.resp", r.resp, got.resp);
		end
		@(posedge clk);
		#1;
		r_ready = 1'b1;
		@(posedge clk);
		#1;
		r_ready = 1'b0;
	endtask

	task automatic accept_b(output resp_t got);
		int stall;
		stall = (bp_max > 0) ? rand_below(bp_max + 1) : 0;
		got = b_resp;
		repeat (stall) begin
			@(posedge clk);
			#1;
			@(negedge clk);
			check_flag(b_valid, "b_valid dropped before b_ready");
			check_bresp("b_resp", b_resp, got);
		end
		@(posedge clk);
		#1;
		b_ready = 1'b1;
		@(posedge clk);
		#1;
		b_ready = 1'b0;
	endtask

	task automatic do_read(input addr_t a);
		int hs_edge;
		r_rsp_t got;
		resp_t exp_resp;
		exp_resp = addr_in_range(a) ? RESP_OKAY : RESP_SLVERR;
		ar.addr = a;
		handshake(chan_ar);
		hs_edge = cycle_count;
		check_flag(!ar_ready, "ar_ready stayed high after the read address handshake");
		wait_high(chan_r);
		check_latency("r_valid", cycle_count - hs_edge);
		accept_r(got);
		check_flag(ar_ready, "ar_ready did not return after the read response");
		check_rresp("r.resp", got.resp, exp_resp);
		if (exp_resp == RESP_OKAY) begin
			check_rdata("r.data", got.data, model_word(word_slot(a)));
		end
	endtask

	// order 0 sends aw first, 1 sends w first, 2 sends both together.
	task automatic do_write(input addr_t a, input word_t d, input strb_t s,
		input int order, input int gap);
		int later;
		resp_t got;
		resp_t exp_resp;
		chan_t first;
		chan_t second;
		exp_resp = addr_in_range(a) ? RESP_OKAY : RESP_SLVERR;
		aw.addr = a;
		w.data = d;
		w.strb = s;
		if (order == 2) begin
			aw_valid = 1'b1;
			w_valid = 1'b1;
			wait_high(chan_aw);
			check_flag(w_ready, "w_ready low while the write side is idle");
			@(posedge clk);
			#1;
			aw_valid = 1'b0;
			w_valid = 1'b0;
		end else begin
			first = (order == 0) ? chan_aw : chan_w;
			second = (order == 0) ? chan_w : chan_aw;
			handshake(first);
			check_flag(!chan_level(first), "a write ready stayed high after its handshake");
			check_flag(chan_level(second), "the other write ready dropped too early");
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
			handshake(second);
		end
		later = cycle_count;
		wait_high(chan_b);
		check_latency("b_valid", cycle_count - later);
		accept_b(got);
		check_flag(aw_ready && w_ready, "write readies did not return after the response");
		check_bresp("b_resp", got, exp_resp);
		if (exp_resp == RESP_OKAY) begin
			model_write(word_slot(a), d, s);
		end
	endtask

	initial begin
		int slot;
		addr_t a;
		strb_t s;
		reset = 1'b1;
		ar = '0;
		ar_valid = 1'b0;
		r_ready = 1'b0;
		aw = '0;
		aw_valid = 1'b0;
		w = '0;
		w_valid = 1'b0;
		b_ready = 1'b0;
		cfg_wen = 1'b0;
		cfg_mask = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		check_flag(ar_ready && aw_ready && w_ready, "readies not high after reset");
		check_flag(!r_valid && !b_valid, "a response valid is high after reset");

		// full words first, so every later read hits known bytes.
		repeat (16) begin
			slot = rand_below(`SRAM_DEPTH);
			do_write(addr_t'(slot * BYTES), rand_word(), '1, rand_below(3), rand_below(3));
			written.push_back(slot);
		end
		foreach (written[i]) begin
			do_read(addr_t'(written[i] * BYTES));
		end

		repeat (16) begin
			a = addr_t'(written[rand_below(written.size())] * BYTES);
			s = strb_t'(rand_below(1 << BYTES));
			do_write(a, rand_word(), s, rand_below(3), rand_below(3));
			do_read(a);
		end

		// out of range, then the aliased word must be unchanged.
		repeat (6) begin
			slot = written[rand_below(written.size())];
			a = addr_t'((slot + (1 + rand_below(64)) * `SRAM_DEPTH) * BYTES);
			do_write(a, rand_word(), '1, rand_below(3), rand_below(3));
			do_read(a);
			do_read(addr_t'(slot * BYTES));
		end
		do_write(32'hffff_fffc, rand_word(), '1, 2, 0);
		do_read(32'hffff_fffc);

		set_mask('0);
		repeat (8) begin
			a = addr_t'(written[rand_below(written.size())] * BYTES);
			do_write(a, rand_word(), strb_t'(rand_below(1 << BYTES)), rand_below(3), 0);
			do_read(a);
		end

		bp_max = 4;
		repeat (3) begin
			set_mask(mask_t'(1 + rand_below(15)));
			repeat (20) begin
				if (rand_below(2) == 0) begin
					do_write(pick_addr(), rand_word(), strb_t'(rand_below(1 << BYTES)),
						rand_below(3), rand_below(4));
				end else begin
					do_read(pick_addr());
				end
			end
		end

		finish_run();
	end

endmodule

`default_nettype wire
